//--- dv/ext_harness_patterns.txt
# op addr wdata be expected, hex fields after the op letter
# W write, R read and compare, S compare switch outputs, P poll status until it matches
W 20000000 11223344 f 00000000
W 20001000 a5a5a5a5 f 00000000
R 20000000 00000000 0 11223344
R 20001000 00000000 0 a5a5a5a5
W 20000004 cafef00d f 00000000
W 20001004 0badf00d f 00000000
W 20000004 0000ee00 2 00000000
W 20001004 77000011 9 00000000
R 20000004 00000000 0 cafeee0d
R 20001004 00000000 0 77adf011
W 20000008 ffffffff f 00000000
W 20000008 12345678 c 00000000
R 20000008 00000000 0 1234ffff
R 30000000 00000000 0 badc0de0
W 10000000 deadbeef f 00000000
R 20003000 00000000 0 badc0de0
W 20002000 00000005 f 00000000
W 20002004 00000002 f 00000000
S 00000000 00000000 0 00000205
R 20002008 00000000 0 00000000
P 20002008 00000000 0 00000205
R 20002000 00000000 0 00000005
R 20002004 00000000 0 00000002
R 20000000 00000000 0 11223344

//--- filelist.f
design/ext_harness_pkg.sv
design/switch_ack_delay.sv
design/power_switch_ctrl.sv
design/slow_memory.sv
design/ext_bus_demux.sv
design/ext_harness_top.sv
dv/tb_clk_gen.sv
dv/ext_harness_chk.sv
dv/tb_ext_harness.sv

//--- Bender.yml
package:
  name: ext_harness

sources:
  - files:
      - design/ext_harness_pkg.sv
      - design/switch_ack_delay.sv
      - design/power_switch_ctrl.sv
      - design/slow_memory.sv
      - design/ext_bus_demux.sv
      - design/ext_harness_top.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/ext_harness_chk.sv
      - dv/tb_ext_harness.sv

//--- dv/tb_ext_harness.sv
// testbench for the external-device harness
// replays the pattern file over the bus, checks read data, switches and response count
`default_nettype none

module tb_ext_harness
  import ext_harness_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam string PATTERN_FILE = "dv/ext_harness_patterns.txt";
  localparam int unsigned WAIT_LIMIT = 40;
  localparam int unsigned POLL_LIMIT = 20;

  logic clk, rst, req, we, gnt, rvalid;
  addr_t addr;
  be_t be;
  data_t wdata, rdata;
  domain_vec_t domain_sw;
  bank_vec_t bank_sw;

  int data_errs, switch_errs, bank_errs, other_errs;
  int accepted, responses;
  logic [31:0] rand_state;
  data_t mem_model [addr_t];

  tb_clk_gen clk_gen (.clk_o(clk), .rst_o(rst));

  ext_harness_top dut0 (
    .clk_i(clk), .rst_i(rst), .req_i(req), .addr_i(addr), .we_i(we), .be_i(be),
    .wdata_i(wdata), .gnt_o(gnt), .rvalid_o(rvalid), .rdata_o(rdata),
    .domain_switch_n_o(domain_sw), .bank_switch_n_o(bank_sw)
  );

  bind ext_harness_top ext_harness_chk chk0 (
    .clk_i(clk_i), .rst_i(rst_i), .req_i(req_i), .gnt_i(gnt_o), .rvalid_i(rvalid_o),
    .domain_switch_n_i(domain_switch_n_o), .bank_switch_n_i(bank_switch_n_o)
  );

  // response counter, sampled mid-cycle
  always @(negedge clk) begin
    if (!rst && rvalid) responses++;
  end

  function automatic logic [31:0] next_random(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic is_mem_addr(input addr_t a);
    return (a >= SLOW_MEM0_BASE && a < SLOW_MEM0_BASE + TARGET_SPAN) ||
           (a >= SLOW_MEM1_BASE && a < SLOW_MEM1_BASE + TARGET_SPAN);
  endfunction

  // word index repeats every 1 KiB inside a 4 KiB window
  function automatic addr_t mem_key(input addr_t a);
    return {a[31:12], 2'b00, a[9:2], 2'b00};
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t d, input be_t b);
    data_t res;
    res = old;
    for (int i = 0; i < BE_WIDTH; i++) begin
      if (b[i]) res[8*i +: 8] = d[8*i +: 8];
    end
    return res;
  endfunction

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
      data_errs++;
    end
  endtask

  task automatic check_switch(input string name, input domain_vec_t got, input domain_vec_t exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
      switch_errs++;
    end
  endtask

  task automatic check_bank(input string name, input bank_vec_t got, input bank_vec_t exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
      bank_errs++;
    end
  endtask

  // one OBI transaction, ok is low after a timeout
  task automatic bus_transfer(input logic is_write, input addr_t a, input data_t d,
                              input be_t b, output data_t rd, output logic ok);
    int cycles;
    ok = 1'b0;
    rd = '0;
    @(posedge clk);
    #1;
    req = 1'b1;
    we = is_write;
    addr = a;
    be = b;
    wdata = d;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!gnt && cycles < WAIT_LIMIT);
    if (!gnt) begin
      $display("timeout: no grant for address %h within %0d cycles", a, WAIT_LIMIT);
      other_errs++;
    end else begin
      @(posedge clk);
      accepted++;
      #1;
      req = 1'b0;
      we = 1'b0;
      be = '0;
      wdata = '0;
      cycles = 0;
      do begin
        @(negedge clk);
        cycles++;
      end while (!rvalid && cycles < WAIT_LIMIT);
      if (rvalid) begin
        rd = rdata;
        ok = 1'b1;
      end else begin
        $display("timeout: no response for address %h within %0d cycles", a, WAIT_LIMIT);
        other_errs++;
      end
    end
  endtask

  initial begin
    int fd, n, cycles, polls;
    string line;
    logic [7:0] op;
    addr_t a;
    data_t d, exp, rd, old;
    be_t b;
    logic ok;
    req = 1'b0;
    we = 1'b0;
    addr = '0;
    be = '0;
    wdata = '0;
    {data_errs, switch_errs, bank_errs, other_errs, accepted, responses} = '0;
    rand_state = 32'hb25;
    ok = 1'b1;
    cycles = 0;
    while (rst !== 1'b0 && cycles < 10) begin
      @(posedge clk);
      cycles++;
    end
    if (rst !== 1'b0) begin
      $display("reset still asserted after %0d cycles", cycles);
      other_errs++;
      ok = 1'b0;
    end
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      $display("could not open the pattern file %s", PATTERN_FILE);
      other_errs++;
      ok = 1'b0;
    end
    while (ok && $fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%c %h %h %h %h", op, a, d, b, exp);
      if (n != 5) begin
        $display("unreadable pattern line: %s", line);
        other_errs++;
        continue;
      end
      // idle gap of 0 to 3 cycles before each bus operation
      if (op != "S") begin
        rand_state = next_random(rand_state);
        repeat (rand_state[1:0]) @(posedge clk);
      end
      case (op)
        "W": begin
          bus_transfer(1'b1, a, d, b, rd, ok);
          if (ok && is_mem_addr(a)) begin
            old = mem_model.exists(mem_key(a)) ? mem_model[mem_key(a)] : 'x;
            mem_model[mem_key(a)] = merge_bytes(old, d, b);
          end
        end
        "R": begin
          bus_transfer(1'b0, a, '0, '0, rd, ok);
          if (ok) begin
            check_data("rdata_o", rd, exp);
            if (is_mem_addr(a) && mem_model.exists(mem_key(a))) begin
              check_data("rdata_o vs model", rd, mem_model[mem_key(a)]);
            end
          end
        end
        "S": begin
          check_switch("domain_switch_n_o", domain_sw, exp[NUM_DOMAINS-1:0]);
          check_bank("bank_switch_n_o", bank_sw, exp[8 +: NUM_BANKS]);
        end
        "P": begin
          polls = 0;
          do begin
            bus_transfer(1'b0, a, '0, '0, rd, ok);
            polls++;
          end while (ok && rd !== exp && polls < POLL_LIMIT);
          if (ok && rd !== exp) begin
            $display("status never read %h within %0d polls, last %h", exp, POLL_LIMIT, rd);
            other_errs++;
          end else if (ok) begin
            // acknowledged values must still be driven on the switch outputs
            check_switch("domain_switch_n_o", domain_sw, exp[NUM_DOMAINS-1:0]);
            check_bank("bank_switch_n_o", bank_sw, exp[8 +: NUM_BANKS]);
          end
        end
        default: begin
          $display("unknown operation in pattern line: %s", line);
          other_errs++;
        end
      endcase
    end
    if (fd != 0) $fclose(fd);
    repeat (3) @(posedge clk);
    if (responses != accepted) begin
      $display("%0d requests accepted but %0d responses seen", accepted, responses);
      other_errs++;
    end
    $display("errors: data %0d, switch %0d, bank %0d, other %0d (requests %0d)",
             data_errs, switch_errs, bank_errs, other_errs, accepted);
    if (data_errs + switch_errs + bank_errs + other_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/ext_harness_chk.sv
// concurrent checks on the harness bus handshake and the switch reset state
// bound into ext_harness_top by the testbench
`default_nettype none

module ext_harness_chk
  import ext_harness_pkg::*;
(
  input wire         clk_i,
  input wire         rst_i,
  input wire         req_i,
  input wire         gnt_i,
  input wire         rvalid_i,
  input domain_vec_t domain_switch_n_i,
  input bank_vec_t   bank_switch_n_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic outstanding_q;

  // a new accept may land in the response cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      outstanding_q <= 1'b0;
    end else begin
      outstanding_q <= (outstanding_q & ~rvalid_i) | (req_i & gnt_i);
    end
  end

  // grant needs a live request and no pending response
  grant_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
    gnt_i |-> (req_i && (!outstanding_q || rvalid_i)))
    else $error("grant seen without req_i or while a transaction is outstanding");

  rvalid_needs_request: assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid_i |-> outstanding_q)
    else $error("rvalid seen with no outstanding transaction");

  switches_on_after_reset: assert property (@(posedge clk_i)
    rst_i |=> (domain_switch_n_i == '0 && bank_switch_n_i == '0))
    else $error("switch outputs not zero after reset");

endmodule

`default_nettype wire

//--- dv/tb_clk_gen.sv
// clock and reset source for the harness testbench
// 10 ns clock, reset held high for the first two rising edges
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned HALF_PERIOD = 5;
  localparam int unsigned RST_CYCLES = 2;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // release just after an edge, like the other inputs
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- design/ext_harness_top.sv
// external-device harness: bus demux, two slow memories and the power controller
// drive the bus ports like an OBI master, switch outputs go to the power domains
`default_nettype none

module ext_harness_top
  import ext_harness_pkg::*;
(
  input  wire         clk_i,
  input  wire         rst_i,
  input  wire         req_i,
  input  addr_t       addr_i,
  input  wire         we_i,
  input  be_t         be_i,
  input  data_t       wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output data_t       rdata_o,
  output domain_vec_t domain_switch_n_o,
  output bank_vec_t   bank_switch_n_o
);

  logic [NUM_TARGETS-1:0]  tgt_req;
  addr_t [NUM_TARGETS-1:0] tgt_addr;
  logic [NUM_TARGETS-1:0]  tgt_we;
  be_t [NUM_TARGETS-1:0]   tgt_be;
  data_t [NUM_TARGETS-1:0] tgt_wdata;
  logic [NUM_TARGETS-1:0]  tgt_gnt;
  logic [NUM_TARGETS-1:0]  tgt_rvalid;
  data_t [NUM_TARGETS-1:0] tgt_rdata;

  ext_bus_demux bus_demux (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .addr_i      (addr_i),
    .we_i        (we_i),
    .be_i        (be_i),
    .wdata_i     (wdata_i),
    .gnt_o       (gnt_o),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o),
    .tgt_req_o   (tgt_req),
    .tgt_addr_o  (tgt_addr),
    .tgt_we_o    (tgt_we),
    .tgt_be_o    (tgt_be),
    .tgt_wdata_o (tgt_wdata),
    .tgt_gnt_i   (tgt_gnt),
    .tgt_rvalid_i(tgt_rvalid),
    .tgt_rdata_i (tgt_rdata)
  );

  // word index from the byte address
  slow_memory slow_mem0 (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .req_i   (tgt_req[SLOW_MEM0_IDX]),
    .we_i    (tgt_we[SLOW_MEM0_IDX]),
    .addr_i  (tgt_addr[SLOW_MEM0_IDX][2 +: $bits(mem_addr_t)]),
    .be_i    (tgt_be[SLOW_MEM0_IDX]),
    .wdata_i (tgt_wdata[SLOW_MEM0_IDX]),
    .gnt_o   (tgt_gnt[SLOW_MEM0_IDX]),
    .rvalid_o(tgt_rvalid[SLOW_MEM0_IDX]),
    .rdata_o (tgt_rdata[SLOW_MEM0_IDX])
  );

  slow_memory slow_mem1 (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .req_i   (tgt_req[SLOW_MEM1_IDX]),
    .we_i    (tgt_we[SLOW_MEM1_IDX]),
    .addr_i  (tgt_addr[SLOW_MEM1_IDX][2 +: $bits(mem_addr_t)]),
    .be_i    (tgt_be[SLOW_MEM1_IDX]),
    .wdata_i (tgt_wdata[SLOW_MEM1_IDX]),
    .gnt_o   (tgt_gnt[SLOW_MEM1_IDX]),
    .rvalid_o(tgt_rvalid[SLOW_MEM1_IDX]),
    .rdata_o (tgt_rdata[SLOW_MEM1_IDX])
  );

  // full-word registers, byte enables not needed
  power_switch_ctrl pwr_ctrl (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .req_i            (tgt_req[PWR_CTRL_IDX]),
    .we_i             (tgt_we[PWR_CTRL_IDX]),
    .offset_i         (tgt_addr[PWR_CTRL_IDX][3:0]),
    .wdata_i          (tgt_wdata[PWR_CTRL_IDX]),
    .gnt_o            (tgt_gnt[PWR_CTRL_IDX]),
    .rvalid_o         (tgt_rvalid[PWR_CTRL_IDX]),
    .rdata_o          (tgt_rdata[PWR_CTRL_IDX]),
    .domain_switch_n_o(domain_switch_n_o),
    .bank_switch_n_o  (bank_switch_n_o)
  );

endmodule

`default_nettype wire

//--- design/ext_bus_demux.sv
// decodes the bus address and routes requests to the harness targets
// one transaction in flight, unmapped addresses answer BAD_ADDR_DATA
`default_nettype none

module ext_bus_demux
  import ext_harness_pkg::*;
(
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire                     req_i,
  input  addr_t                   addr_i,
  input  wire                     we_i,
  input  be_t                     be_i,
  input  data_t                   wdata_i,
  output logic                    gnt_o,
  output logic                    rvalid_o,
  output data_t                   rdata_o,
  output logic [NUM_TARGETS-1:0]  tgt_req_o,
  output addr_t [NUM_TARGETS-1:0] tgt_addr_o,
  output logic [NUM_TARGETS-1:0]  tgt_we_o,
  output be_t [NUM_TARGETS-1:0]   tgt_be_o,
  output data_t [NUM_TARGETS-1:0] tgt_wdata_o,
  input  wire [NUM_TARGETS-1:0]   tgt_gnt_i,
  input  wire [NUM_TARGETS-1:0]   tgt_rvalid_i,
  input  data_t [NUM_TARGETS-1:0] tgt_rdata_i
);

  target_idx_t dec_idx;
  logic        dec_hit;
  target_idx_t sel_q;
  logic        busy_q;
  logic        miss_q;
  logic        can_issue;
  logic        accept;

  function automatic logic in_window(addr_t addr, addr_t base);
    addr_t rel;
    rel = addr - base;
    return rel < TARGET_SPAN;
  endfunction

  always_comb begin
    dec_hit = 1'b1;
    if (in_window(addr_i, SLOW_MEM0_BASE)) begin
      dec_idx = SLOW_MEM0_IDX;
    end else if (in_window(addr_i, SLOW_MEM1_BASE)) begin
      dec_idx = SLOW_MEM1_IDX;
    end else if (in_window(addr_i, PWR_CTRL_BASE)) begin
      dec_idx = PWR_CTRL_IDX;
    end else begin
      dec_idx = SLOW_MEM0_IDX;
      dec_hit = 1'b0;
    end
  end

  // a miss is answered by the demux itself one cycle later
  assign rvalid_o  = busy_q & (miss_q | tgt_rvalid_i[sel_q]);
  assign rdata_o   = miss_q ? BAD_ADDR_DATA : tgt_rdata_i[sel_q];
  assign can_issue = ~busy_q | rvalid_o;
  assign gnt_o     = req_i & can_issue & (~dec_hit | tgt_gnt_i[dec_idx]);
  assign accept    = req_i & gnt_o;

  always_comb begin
    for (int i = 0; i < NUM_TARGETS; i++) begin
      tgt_req_o[i]   = req_i & can_issue & dec_hit & (dec_idx == target_idx_t'(i));
      tgt_addr_o[i]  = addr_i;
      tgt_we_o[i]    = we_i;
      tgt_be_o[i]    = be_i;
      tgt_wdata_o[i] = wdata_i;
    end
  end

  // remember where the outstanding response comes from
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
      sel_q  <= SLOW_MEM0_IDX;
      miss_q <= 1'b0;
    end else if (accept) begin
      busy_q <= 1'b1;
      sel_q  <= dec_idx;
      miss_q <= ~dec_hit;
    end else if (rvalid_o) begin
      busy_q <= 1'b0;
      miss_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- design/slow_memory.sv
// word memory with byte enables that answers SLOW_MEM_LATENCY cycles after grant
// takes one request at a time, a new one may be granted in the response cycle
`default_nettype none

module slow_memory
  import ext_harness_pkg::*;
(
  input  wire       clk_i,
  input  wire       rst_i,
  input  wire       req_i,
  input  wire       we_i,
  input  mem_addr_t addr_i,
  input  be_t       be_i,
  input  data_t     wdata_i,
  output logic      gnt_o,
  output logic      rvalid_o,
  output data_t     rdata_o
);

  localparam int unsigned CNT_W = $clog2(SLOW_MEM_LATENCY + 1);

  data_t            mem_q [MEM_WORDS];
  data_t            rdata_q;
  logic             busy_q;
  logic [CNT_W-1:0] cnt_q;
  logic             last;
  logic             accept;

  // response cycle is the last one of the countdown
  assign last     = busy_q & (cnt_q == '0);
  assign gnt_o    = ~busy_q | last;
  assign accept   = req_i & gnt_o;
  assign rvalid_o = last;
  assign rdata_o  = rdata_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (accept) begin
      busy_q <= 1'b1;
      cnt_q  <= CNT_W'(SLOW_MEM_LATENCY - 1);
    end else if (last) begin
      busy_q <= 1'b0;
    end else if (busy_q) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // storage and read capture, sampled at acceptance
  always_ff @(posedge clk_i) begin
    if (accept && we_i) begin
      for (int b = 0; b < BE_WIDTH; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
    if (accept && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

endmodule

`default_nettype wire

//--- design/power_switch_ctrl.sv
// domain and bank power-switch registers on the harness bus
// status offset reads back the delayed switch acknowledges
`default_nettype none

module power_switch_ctrl
  import ext_harness_pkg::*;
(
  input  wire         clk_i,
  input  wire         rst_i,
  input  wire         req_i,
  input  wire         we_i,
  input  wire  [3:0]  offset_i,
  input  data_t       wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output data_t       rdata_o,
  output domain_vec_t domain_switch_n_o,
  output bank_vec_t   bank_switch_n_o
);

  domain_vec_t domain_q;
  bank_vec_t   bank_q;
  domain_vec_t domain_ack_n;
  bank_vec_t   bank_ack_n;
  data_t       read_data;
  logic        accept;

  // plain register file, never stalls
  assign gnt_o  = 1'b1;
  assign accept = req_i & gnt_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      domain_q <= '0;
      bank_q   <= '0;
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= accept;
      if (accept && we_i && offset_i == PWR_DOMAIN_OFS) begin
        domain_q <= wdata_i[NUM_DOMAINS-1:0];
      end
      if (accept && we_i && offset_i == PWR_BANK_OFS) begin
        bank_q <= wdata_i[NUM_BANKS-1:0];
      end
    end
  end

  // status: domain acks in 3:0, bank acks in 9:8
  always_comb begin
    read_data = '0;
    case (offset_i)
      PWR_DOMAIN_OFS: read_data[NUM_DOMAINS-1:0] = domain_q;
      PWR_BANK_OFS:   read_data[NUM_BANKS-1:0] = bank_q;
      PWR_STATUS_OFS: begin
        read_data[NUM_DOMAINS-1:0] = domain_ack_n;
        read_data[8 +: NUM_BANKS]  = bank_ack_n;
      end
      default: read_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (accept && !we_i) begin
      rdata_o <= read_data;
    end
  end

  switch_ack_delay #(.ack_t(domain_vec_t)) domain_ack_delay (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .switch_n_i    (domain_q),
    .switch_ack_n_o(domain_ack_n)
  );

  switch_ack_delay #(.ack_t(bank_vec_t)) bank_ack_delay (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .switch_n_i    (bank_q),
    .switch_ack_n_o(bank_ack_n)
  );

  assign domain_switch_n_o = domain_q;
  assign bank_switch_n_o   = bank_q;

endmodule

`default_nettype wire

//--- design/switch_ack_delay.sv
// emulates the acknowledge delay of power-switch cells
// the acknowledge follows the switch request SWITCH_ACK_LATENCY cycles later
`default_nettype none

module switch_ack_delay
  import ext_harness_pkg::*;
#(
  parameter type ack_t = logic
) (
  input  wire  clk_i,
  input  wire  rst_i,
  input  ack_t switch_n_i,
  output ack_t switch_ack_n_o
);

  ack_t stage_q [SWITCH_ACK_LATENCY];

  // shift register, stage 0 samples the switch request
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= switch_n_i;
      for (int i = 1; i < SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign switch_ack_n_o = stage_q[SWITCH_ACK_LATENCY-1];

endmodule

`default_nettype wire

//--- design/ext_harness_pkg.sv
// shared widths, address map and latencies of the external-device harness
// imported by every RTL module of the harness
`default_nettype none

package ext_harness_pkg;

  // bus widths
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BE_WIDTH = DATA_WIDTH / 8;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [BE_WIDTH-1:0] be_t;

  // bus targets behind the decoder
  localparam int unsigned NUM_TARGETS = 3;
  typedef logic [1:0] target_idx_t;

  localparam target_idx_t SLOW_MEM0_IDX = 2'd0;
  localparam target_idx_t SLOW_MEM1_IDX = 2'd1;
  localparam target_idx_t PWR_CTRL_IDX = 2'd2;

  // address map, one 4 KiB window per target
  localparam addr_t SLOW_MEM0_BASE = 32'h2000_0000;
  localparam addr_t SLOW_MEM1_BASE = 32'h2000_1000;
  localparam addr_t PWR_CTRL_BASE = 32'h2000_2000;
  localparam addr_t TARGET_SPAN = 32'h0000_1000;

  // slow memories
  localparam int unsigned MEM_WORDS = 256;
  typedef logic [$clog2(MEM_WORDS)-1:0] mem_addr_t;
  localparam int unsigned SLOW_MEM_LATENCY = 4;

  // power switches, active-low like the switch cells they drive
  localparam int unsigned NUM_DOMAINS = 4;
  localparam int unsigned NUM_BANKS = 2;
  typedef logic [NUM_DOMAINS-1:0] domain_vec_t;
  typedef logic [NUM_BANKS-1:0] bank_vec_t;
  localparam int unsigned SWITCH_ACK_LATENCY = 15;

  // power controller register offsets
  localparam logic [3:0] PWR_DOMAIN_OFS = 4'h0;
  localparam logic [3:0] PWR_BANK_OFS = 4'h4;
  localparam logic [3:0] PWR_STATUS_OFS = 4'h8;

  // read data for an address outside every window
  localparam data_t BAD_ADDR_DATA = 32'hbadc0de0;

endpackage

`default_nettype wire
